// ==== common/clockDisplayPkg.sv ====
package clockDisplayPkg;

	typedef logic [11:0] rgbColor;                      // 4 bits per channel

	typedef enum logic [3:0] {
		fieldDay, fieldMonth, fieldYear,
		fieldHour, fieldMinute, fieldSecond,
		fieldTimerHour, fieldTimerMinute, fieldTimerSecond
	} fieldIndex;                                       // Left to right on screen

	localparam int fieldCount = 9;

	////////////////////////////////////////
	// Port bus
	localparam logic [7:0] addrSeconds = 8'h02;
	localparam logic [7:0] addrMinutes = 8'h03;
	localparam logic [7:0] addrHours = 8'h04;
	localparam logic [7:0] addrDay = 8'h05;
	localparam logic [7:0] addrMonth = 8'h06;
	localparam logic [7:0] addrYear = 8'h07;
	localparam logic [7:0] addrTimerSeconds = 8'h08;
	localparam logic [7:0] addrTimerMinutes = 8'h09;
	localparam logic [7:0] addrTimerHours = 8'h0A;
	localparam logic [7:0] addrPointer = 8'h0E;

	localparam logic [7:0] pointDay = 8'h26;            // Edit pointer codes
	localparam logic [7:0] pointMonth = 8'h25;
	localparam logic [7:0] pointYear = 8'h24;
	localparam logic [7:0] pointHour = 8'h23;
	localparam logic [7:0] pointMinute = 8'h22;
	localparam logic [7:0] pointSecond = 8'h21;
	localparam logic [7:0] pointTimerHour = 8'h43;
	localparam logic [7:0] pointTimerMinute = 8'h42;
	localparam logic [7:0] pointTimerSecond = 8'h41;

	localparam logic [7:0] resetYear = 8'h10;           // Power-up contents
	localparam logic [7:0] resetMonth = 8'h20;
	localparam logic [7:0] resetDay = 8'h30;
	localparam logic [7:0] resetHour = 8'h40;
	localparam logic [7:0] resetMinute = 8'h50;
	localparam logic [7:0] resetSecond = 8'h60;
	localparam logic [7:0] resetTimerHour = 8'h70;
	localparam logic [7:0] resetTimerMinute = 8'h80;
	localparam logic [7:0] resetTimerSecond = 8'h90;
	localparam logic [7:0] resetPointer = 8'h00;

	localparam logic [7:0] hourLimit = 8'h23;           // BCD
	localparam logic [7:0] minuteLimit = 8'h59;

	////////////////////////////////////////
	// 640x480 raster at 25 MHz
	localparam logic [9:0] hVisible = 10'd640;
	localparam logic [9:0] hFrontPorch = 10'd16;
	localparam logic [9:0] hSyncWidth = 10'd96;
	localparam logic [9:0] hBackPorch = 10'd48;
	localparam logic [9:0] hTotal = hVisible + hFrontPorch + hSyncWidth + hBackPorch;
	localparam logic [9:0] vVisible = 10'd480;
	localparam logic [9:0] vFrontPorch = 10'd10;
	localparam logic [9:0] vSyncWidth = 10'd2;
	localparam logic [9:0] vBackPorch = 10'd33;
	localparam logic [9:0] vTotal = vVisible + vFrontPorch + vSyncWidth + vBackPorch;

	localparam logic [9:0] digitLeft = 10'd64;          // Field 0 origin
	localparam logic [9:0] fieldPitch = 10'd40;
	localparam logic [9:0] digitWidth = 10'd16;
	localparam logic [9:0] digitTop = 10'd200;
	localparam logic [9:0] digitHeight = 10'd24;

	localparam logic [3:0] segBarLo = 4'd3;             // Cell columns of bars a g d
	localparam logic [3:0] segBarHi = 4'd12;
	localparam logic [3:0] segLeftHi = 4'd2;            // f and e
	localparam logic [3:0] segRightLo = 4'd13;          // b and c
	localparam logic [4:0] segTopHi = 5'd2;             // Cell rows
	localparam logic [4:0] segMidLo = 5'd11;
	localparam logic [4:0] segMidHi = 5'd13;
	localparam logic [4:0] segBottomLo = 5'd21;
	localparam logic [4:0] segUpperLo = 5'd2;
	localparam logic [4:0] segUpperHi = 5'd11;
	localparam logic [4:0] segLowerLo = 5'd13;
	localparam logic [4:0] segLowerHi = 5'd22;

	localparam logic [9:0] upXLo = 10'd490;             // Box bounds inclusive
	localparam logic [9:0] upXHi = 10'd521;
	localparam logic [9:0] upYLo = 10'd67;
	localparam logic [9:0] upYHi = 10'd92;
	localparam logic [9:0] downXLo = 10'd490;
	localparam logic [9:0] downXHi = 10'd521;
	localparam logic [9:0] downYLo = 10'd95;
	localparam logic [9:0] downYHi = 10'd115;
	localparam logic [9:0] rightXLo = 10'd522;
	localparam logic [9:0] rightXHi = 10'd550;
	localparam logic [9:0] rightYLo = 10'd95;
	localparam logic [9:0] rightYHi = 10'd115;
	localparam logic [9:0] leftXLo = 10'd465;
	localparam logic [9:0] leftXHi = 10'd487;
	localparam logic [9:0] leftYLo = 10'd95;
	localparam logic [9:0] leftYHi = 10'd115;
	localparam logic [9:0] alarmXLo = 10'd440;
	localparam logic [9:0] alarmXHi = 10'd455;
	localparam logic [9:0] alarmYLo = 10'd200;
	localparam logic [9:0] alarmYHi = 10'd223;

	localparam rgbColor colorWhite = 12'hFFF;
	localparam rgbColor colorBlack = 12'h000;
	localparam rgbColor colorRed = 12'hF00;

	localparam logic [7:0] keyUp = 8'h75;               // PS/2 set 2 make codes
	localparam logic [7:0] keyDown = 8'h72;
	localparam logic [7:0] keyRight = 8'h74;
	localparam logic [7:0] keyLeft = 8'h6B;
	localparam logic [7:0] breakCode = 8'hF0;

	// Segments as {a,b,c,d,e,f,g}
	function automatic logic [6:0] segmentPattern(input logic [3:0] digit);
		case (digit)
			4'd0: return 7'b1111110;
			4'd1: return 7'b0110000;
			4'd2: return 7'b1101101;
			4'd3: return 7'b1111001;
			4'd4: return 7'b0110011;
			4'd5: return 7'b1011011;
			4'd6: return 7'b1011111;
			4'd7: return 7'b1110000;
			4'd8: return 7'b1111111;
			4'd9: return 7'b1111011;
			default: return 7'b0000000;              // Not BCD
		endcase
	endfunction

	function automatic logic inBox(input logic [9:0] x, input logic [9:0] y,
		input logic [9:0] xLo, input logic [9:0] xHi,
		input logic [9:0] yLo, input logic [9:0] yHi);
		return (x >= xLo) && (x <= xHi) && (y >= yLo) && (y <= yHi);  // Inclusive bounds
	endfunction

endpackage

// ==== common/clockFieldsIf.sv ====
`timescale 1ns/1ps

interface clockFieldsIf;

	logic [7:0] value [clockDisplayPkg::fieldCount];   // BCD field registers in screen order
	logic [7:0] pointer;                                // Edit pointer code

	modport source
	(
		output value,
		output pointer
	);

	modport sink
	(
		input value,
		input pointer
	);

endinterface

// ==== common/rasterIf.sv ====
`timescale 1ns/1ps

interface rasterIf;

	logic [9:0] hPos;                                   // Column
	logic [9:0] vPos;                                   // Line
	logic hSync;                                        // Active low
	logic vSync;                                        // Active low
	logic videoOn;                                      // Inside 640x480

	modport source (output hPos, output vPos, output hSync, output vSync, output videoOn);
	modport sink (input hPos, input vPos, input hSync, input vSync, input videoOn);

endinterface

// ==== logic/bcdSubtract.sv ====
`timescale 1ns/1ps

module bcdSubtract
(
	input logic [7:0] minuend,
	input logic [7:0] subtrahend,
	output logic [7:0] difference
);

	logic [4:0] unitsRaw;                               // Bit 4 flags a negative digit
	logic [4:0] tensRaw;
	logic borrow;

	always_comb
	begin
		unitsRaw = {1'b0, minuend[3:0]} - {1'b0, subtrahend[3:0]};
		borrow = unitsRaw[4];                           // Borrow into tens
		if (borrow)
			unitsRaw = unitsRaw + 5'd10;                // Back into 0..9
		tensRaw = {1'b0, minuend[7:4]} - {1'b0, subtrahend[7:4]} - {4'd0, borrow};
		if (tensRaw[4])
			tensRaw = tensRaw + 5'd10;                  // Wraps modulo 100
	end

	assign difference = {tensRaw[3:0], unitsRaw[3:0]};

endmodule

// ==== logic/portRegisterBank.sv ====
`timescale 1ns/1ps

module portRegisterBank
(
	input logic CLK,
	input logic reset,
	input logic writeStrobe,                            // One cycle per write
	input logic [7:0] portId,
	input logic [7:0] outPort,
	clockFieldsIf.source fields
);

	logic [7:0] remainHour;                             // Limit minus written value
	logic [7:0] remainMinute;
	logic [7:0] remainSecond;

	bcdSubtract hourSub
	(
		.minuend(clockDisplayPkg::hourLimit),
		.subtrahend(outPort),
		.difference(remainHour)
	);

	bcdSubtract minuteSub
	(
		.minuend(clockDisplayPkg::minuteLimit),
		.subtrahend(outPort),
		.difference(remainMinute)
	);

	bcdSubtract secondSub
	(
		.minuend(clockDisplayPkg::minuteLimit),         // Seconds share the 59 limit
		.subtrahend(outPort),
		.difference(remainSecond)
	);

	always_ff @(posedge CLK)
	begin
		if (reset)
		begin
			fields.value[clockDisplayPkg::fieldDay] <= clockDisplayPkg::resetDay;
			fields.value[clockDisplayPkg::fieldMonth] <= clockDisplayPkg::resetMonth;
			fields.value[clockDisplayPkg::fieldYear] <= clockDisplayPkg::resetYear;
			fields.value[clockDisplayPkg::fieldHour] <= clockDisplayPkg::resetHour;
			fields.value[clockDisplayPkg::fieldMinute] <= clockDisplayPkg::resetMinute;
			fields.value[clockDisplayPkg::fieldSecond] <= clockDisplayPkg::resetSecond;
			fields.value[clockDisplayPkg::fieldTimerHour] <= clockDisplayPkg::resetTimerHour;
			fields.value[clockDisplayPkg::fieldTimerMinute] <= clockDisplayPkg::resetTimerMinute;
			fields.value[clockDisplayPkg::fieldTimerSecond] <= clockDisplayPkg::resetTimerSecond;
			fields.pointer <= clockDisplayPkg::resetPointer;
		end
		else if (writeStrobe)
		begin
			case (portId)                               // Unlisted addresses fall through
				clockDisplayPkg::addrDay: fields.value[clockDisplayPkg::fieldDay] <= outPort;
				clockDisplayPkg::addrMonth: fields.value[clockDisplayPkg::fieldMonth] <= outPort;
				clockDisplayPkg::addrYear: fields.value[clockDisplayPkg::fieldYear] <= outPort;
				clockDisplayPkg::addrHours: fields.value[clockDisplayPkg::fieldHour] <= outPort;
				clockDisplayPkg::addrMinutes: fields.value[clockDisplayPkg::fieldMinute] <= outPort;
				clockDisplayPkg::addrSeconds: fields.value[clockDisplayPkg::fieldSecond] <= outPort;
				clockDisplayPkg::addrTimerHours:
					fields.value[clockDisplayPkg::fieldTimerHour] <= remainHour;
				clockDisplayPkg::addrTimerMinutes:
					fields.value[clockDisplayPkg::fieldTimerMinute] <= remainMinute;
				clockDisplayPkg::addrTimerSeconds:
					fields.value[clockDisplayPkg::fieldTimerSecond] <= remainSecond;
				clockDisplayPkg::addrPointer: fields.pointer <= outPort;
				default: ;
			endcase
		end
	end

endmodule

// ==== vga/vgaTiming.sv ====
`timescale 1ns/1ps

module vgaTiming
(
	input logic CLK,
	input logic reset,
	rasterIf.source scan
);

	logic lineEnd;                                      // Last column of a line
	logic frameEnd;                                     // Last line of a frame

	assign lineEnd = (scan.hPos == clockDisplayPkg::hTotal - 10'd1);
	assign frameEnd = (scan.vPos == clockDisplayPkg::vTotal - 10'd1);

	always_ff @(posedge CLK)
	begin
		if (reset)
		begin
			scan.hPos <= '0;
			scan.vPos <= '0;
		end
		else if (lineEnd)
		begin
			scan.hPos <= '0;                            // Wrap at 799
			scan.vPos <= frameEnd ? 10'd0 : scan.vPos + 10'd1;
		end
		else
			scan.hPos <= scan.hPos + 10'd1;
	end

	////////////////////////////////////////
	// Sync pulses from the counters
	assign scan.hSync = !((scan.hPos >= clockDisplayPkg::hVisible + clockDisplayPkg::hFrontPorch)
		&& (scan.hPos < clockDisplayPkg::hVisible + clockDisplayPkg::hFrontPorch
		+ clockDisplayPkg::hSyncWidth));                // Low 656..751
	assign scan.vSync = !((scan.vPos >= clockDisplayPkg::vVisible + clockDisplayPkg::vFrontPorch)
		&& (scan.vPos < clockDisplayPkg::vVisible + clockDisplayPkg::vFrontPorch
		+ clockDisplayPkg::vSyncWidth));                // Low 490..491
	assign scan.videoOn = (scan.hPos < clockDisplayPkg::hVisible)
		&& (scan.vPos < clockDisplayPkg::vVisible);

endmodule

// ==== vga/fieldRenderer.sv ====
`timescale 1ns/1ps

module fieldRenderer
(
	input logic CLK,
	input logic reset,
	rasterIf.sink scan,
	clockFieldsIf.sink fields,
	input logic alarm,
	rasterIf.source pixel,                              // Scan position one cycle later
	output clockDisplayPkg::rgbColor color,
	output logic [3:0] selector
);

	logic inField;                                      // Inside some 40-pixel span
	logic [3:0] fieldNum;
	logic [9:0] fieldStart;
	logic [9:0] fieldOffset;                            // Column within the span
	logic [9:0] rowOffset;
	logic onDigitRow;
	logic inCell;
	logic [3:0] digit;
	logic [6:0] segments;
	logic [3:0] cellCol;
	logic [4:0] cellRow;
	logic segmentLit;
	logic boxLit;
	clockDisplayPkg::rgbColor nextColor;

	////////////////////////////////////////
	// Field and cell lookup
	always_comb
	begin
		inField = 1'b0;
		fieldNum = '0;
		fieldStart = clockDisplayPkg::digitLeft;
		for (int k = 0; k < clockDisplayPkg::fieldCount; k++)
		begin
			if ((scan.hPos >= clockDisplayPkg::digitLeft + 10'(k) * clockDisplayPkg::fieldPitch)
				&& (scan.hPos < clockDisplayPkg::digitLeft
				+ 10'(k + 1) * clockDisplayPkg::fieldPitch))
			begin
				inField = 1'b1;
				fieldNum = 4'(k);
				fieldStart = clockDisplayPkg::digitLeft + 10'(k) * clockDisplayPkg::fieldPitch;
			end
		end
	end

	assign fieldOffset = scan.hPos - fieldStart;
	assign rowOffset = scan.vPos - clockDisplayPkg::digitTop;
	assign onDigitRow = (scan.vPos >= clockDisplayPkg::digitTop)
		&& (scan.vPos < clockDisplayPkg::digitTop + clockDisplayPkg::digitHeight);
	assign inCell = inField && onDigitRow
		&& (fieldOffset < clockDisplayPkg::digitWidth + clockDisplayPkg::digitWidth);
	assign digit = (fieldOffset < clockDisplayPkg::digitWidth)
		? fields.value[fieldNum][7:4]                   // Tens
		: fields.value[fieldNum][3:0];                  // Units
	assign cellCol = fieldOffset[3:0];
	assign cellRow = rowOffset[4:0];
	assign segments = clockDisplayPkg::segmentPattern(digit);

	////////////////////////////////////////
	// Segment hit test
	always_comb
	begin
		segmentLit = 1'b0;
		if (inCell)
		begin
			if ((cellCol >= clockDisplayPkg::segBarLo) && (cellCol <= clockDisplayPkg::segBarHi))
				segmentLit = (segments[6] && (cellRow <= clockDisplayPkg::segTopHi))  // a
					|| (segments[0] && (cellRow >= clockDisplayPkg::segMidLo)
					&& (cellRow <= clockDisplayPkg::segMidHi))                        // g
					|| (segments[3] && (cellRow >= clockDisplayPkg::segBottomLo));    // d
			else if (cellCol <= clockDisplayPkg::segLeftHi)
				segmentLit = (segments[1] && (cellRow >= clockDisplayPkg::segUpperLo)
					&& (cellRow <= clockDisplayPkg::segUpperHi))                      // f
					|| (segments[2] && (cellRow >= clockDisplayPkg::segLowerLo)
					&& (cellRow <= clockDisplayPkg::segLowerHi));                     // e
			else if (cellCol >= clockDisplayPkg::segRightLo)
				segmentLit = (segments[5] && (cellRow >= clockDisplayPkg::segUpperLo)
					&& (cellRow <= clockDisplayPkg::segUpperHi))                      // b
					|| (segments[4] && (cellRow >= clockDisplayPkg::segLowerLo)
					&& (cellRow <= clockDisplayPkg::segLowerHi));                     // c
		end
	end

	// Arrow outlines always drawn and the alarm box only while raised
	assign boxLit = clockDisplayPkg::inBox(scan.hPos, scan.vPos, clockDisplayPkg::upXLo,
			clockDisplayPkg::upXHi, clockDisplayPkg::upYLo, clockDisplayPkg::upYHi)
		|| clockDisplayPkg::inBox(scan.hPos, scan.vPos, clockDisplayPkg::downXLo,
			clockDisplayPkg::downXHi, clockDisplayPkg::downYLo, clockDisplayPkg::downYHi)
		|| clockDisplayPkg::inBox(scan.hPos, scan.vPos, clockDisplayPkg::rightXLo,
			clockDisplayPkg::rightXHi, clockDisplayPkg::rightYLo, clockDisplayPkg::rightYHi)
		|| clockDisplayPkg::inBox(scan.hPos, scan.vPos, clockDisplayPkg::leftXLo,
			clockDisplayPkg::leftXHi, clockDisplayPkg::leftYLo, clockDisplayPkg::leftYHi)
		|| (alarm && clockDisplayPkg::inBox(scan.hPos, scan.vPos, clockDisplayPkg::alarmXLo,
			clockDisplayPkg::alarmXHi, clockDisplayPkg::alarmYLo, clockDisplayPkg::alarmYHi));

	assign nextColor = (scan.videoOn && (segmentLit || boxLit))
		? clockDisplayPkg::colorWhite : clockDisplayPkg::colorBlack;

	always_ff @(posedge CLK)
	begin
		if (reset)
		begin
			color <= clockDisplayPkg::colorBlack;
			selector <= '0;
			pixel.hPos <= '0;
			pixel.vPos <= '0;
			pixel.hSync <= 1'b1;                        // Idle high
			pixel.vSync <= 1'b1;
			pixel.videoOn <= 1'b0;
		end
		else
		begin
			color <= nextColor;
			selector <= (inField && onDigitRow) ? fieldNum + 4'd1 : 4'd0;  // 0 means none
			pixel.hPos <= scan.hPos;
			pixel.vPos <= scan.vPos;
			pixel.hSync <= scan.hSync;
			pixel.vSync <= scan.vSync;
			pixel.videoOn <= scan.videoOn;
		end
	end

endmodule

// ==== vga/highlightOverlay.sv ====
`timescale 1ns/1ps

module highlightOverlay
(
	input logic CLK,
	input logic reset,
	rasterIf.sink pixel,
	input clockDisplayPkg::rgbColor color,
	input logic [3:0] selector,                         // Field index plus one
	clockFieldsIf.sink fields,
	input logic [7:0] keyCode,
	input logic [7:0] keyPrevious,
	output clockDisplayPkg::rgbColor rgb,
	output logic hs,
	output logic vs
);

	logic keyActive;                                    // Not a release
	logic arrowHit;                                     // Held arrow over its box
	logic [3:0] pointerSel;                             // Pointed field plus one
	clockDisplayPkg::rgbColor nextRgb;

	assign keyActive = (keyPrevious != clockDisplayPkg::breakCode);
	assign arrowHit = keyActive && (
		((keyCode == clockDisplayPkg::keyUp) && clockDisplayPkg::inBox(pixel.hPos, pixel.vPos,
			clockDisplayPkg::upXLo, clockDisplayPkg::upXHi,
			clockDisplayPkg::upYLo, clockDisplayPkg::upYHi))
		|| ((keyCode == clockDisplayPkg::keyDown) && clockDisplayPkg::inBox(pixel.hPos, pixel.vPos,
			clockDisplayPkg::downXLo, clockDisplayPkg::downXHi,
			clockDisplayPkg::downYLo, clockDisplayPkg::downYHi))
		|| ((keyCode == clockDisplayPkg::keyRight) && clockDisplayPkg::inBox(pixel.hPos, pixel.vPos,
			clockDisplayPkg::rightXLo, clockDisplayPkg::rightXHi,
			clockDisplayPkg::rightYLo, clockDisplayPkg::rightYHi))
		|| ((keyCode == clockDisplayPkg::keyLeft) && clockDisplayPkg::inBox(pixel.hPos, pixel.vPos,
			clockDisplayPkg::leftXLo, clockDisplayPkg::leftXHi,
			clockDisplayPkg::leftYLo, clockDisplayPkg::leftYHi)));

	always_comb
	begin
		case (fields.pointer)
			clockDisplayPkg::pointDay: pointerSel = 4'(clockDisplayPkg::fieldDay) + 4'd1;
			clockDisplayPkg::pointMonth: pointerSel = 4'(clockDisplayPkg::fieldMonth) + 4'd1;
			clockDisplayPkg::pointYear: pointerSel = 4'(clockDisplayPkg::fieldYear) + 4'd1;
			clockDisplayPkg::pointHour: pointerSel = 4'(clockDisplayPkg::fieldHour) + 4'd1;
			clockDisplayPkg::pointMinute: pointerSel = 4'(clockDisplayPkg::fieldMinute) + 4'd1;
			clockDisplayPkg::pointSecond: pointerSel = 4'(clockDisplayPkg::fieldSecond) + 4'd1;
			clockDisplayPkg::pointTimerHour:
				pointerSel = 4'(clockDisplayPkg::fieldTimerHour) + 4'd1;
			clockDisplayPkg::pointTimerMinute:
				pointerSel = 4'(clockDisplayPkg::fieldTimerMinute) + 4'd1;
			clockDisplayPkg::pointTimerSecond:
				pointerSel = 4'(clockDisplayPkg::fieldTimerSecond) + 4'd1;
			default: pointerSel = 4'd0;                 // Nothing selected
		endcase
	end

	always_comb
	begin
		if (arrowHit && (color == clockDisplayPkg::colorWhite))
			nextRgb = clockDisplayPkg::colorRed;        // Key press wins
		else if ((pointerSel != 4'd0) && (pointerSel == selector)
			&& (color != clockDisplayPkg::colorBlack))
			nextRgb = clockDisplayPkg::colorRed;        // Field under edit
		else
			nextRgb = color;
	end

	always_ff @(posedge CLK)
	begin
		if (reset)
		begin
			rgb <= clockDisplayPkg::colorBlack;
			hs <= 1'b1;
			vs <= 1'b1;
		end
		else
		begin
			rgb <= pixel.videoOn ? nextRgb : clockDisplayPkg::colorBlack;  // Blank outside 640x480
			hs <= pixel.hSync;
			vs <= pixel.vSync;
		end
	end

endmodule

// ==== logic/clockDisplayTop.sv ====
`timescale 1ns/1ps

module clockDisplayTop
(
	input logic CLK,                                    // 25 MHz pixel clock
	input logic reset,
	input logic [7:0] keyCode,                          // Latest PS/2 byte
	input logic [7:0] keyPrevious,                      // Byte before it
	input logic alarm,
	input logic writeStrobe,
	input logic [7:0] portId,
	input logic [7:0] outPort,
	output logic [11:0] rgb,
	output logic hs,
	output logic vs
);

	clockDisplayPkg::rgbColor renderColor;              // Before highlighting
	logic [3:0] renderSelector;

	rasterIf scanRaster();                              // Counter stage
	rasterIf pixelRaster();                             // Render stage
	clockFieldsIf fieldRegs();

	portRegisterBank registers
	(
		.CLK(CLK),
		.reset(reset),
		.writeStrobe(writeStrobe),
		.portId(portId),
		.outPort(outPort),
		.fields(fieldRegs)
	);

	vgaTiming timing
	(
		.CLK(CLK),
		.reset(reset),
		.scan(scanRaster)
	);

	fieldRenderer renderer
	(
		.CLK(CLK),
		.reset(reset),
		.scan(scanRaster),
		.fields(fieldRegs),
		.alarm(alarm),
		.pixel(pixelRaster),
		.color(renderColor),
		.selector(renderSelector)
	);

	highlightOverlay overlay
	(
		.CLK(CLK),
		.reset(reset),
		.pixel(pixelRaster),
		.color(renderColor),
		.selector(renderSelector),
		.fields(fieldRegs),
		.keyCode(keyCode),
		.keyPrevious(keyPrevious),
		.rgb(rgb),
		.hs(hs),
		.vs(vs)
	);

endmodule

// ==== testbench/clockDisplayTb.sv ====
`timescale 1ns/1ps

module clockDisplayTb;

	localparam int frameCycles = 800 * 525;
	localparam int watchdogCycles = 16 * frameCycles;  // About ten frames of tests plus margin

	logic CLK;
	logic reset;
	logic [7:0] keyCode;
	logic [7:0] keyPrevious;
	logic alarm;
	logic writeStrobe;
	logic [7:0] portId;
	logic [7:0] outPort;
	logic [11:0] rgb;
	logic hs;
	logic vs;

	longint cycleCount;                                 // Cycles since reset release
	int errorCount = 0;
	int checkCount = 0;
	logic [7:0] fieldModel [9];                         // Expected register contents
	logic [7:0] pointerModel;

	clockDisplayTop dut_i (.CLK(CLK), .reset(reset), .keyCode(keyCode),
		.keyPrevious(keyPrevious), .alarm(alarm), .writeStrobe(writeStrobe),
		.portId(portId), .outPort(outPort), .rgb(rgb), .hs(hs), .vs(vs));

	initial
	begin
		CLK = 1'b0;
		forever #10 CLK = ~CLK;                         // 20 ns period
	end

	always @(posedge CLK)
		cycleCount <= reset ? 64'sd0 : cycleCount + 64'sd1;

	initial
	begin
		repeat (watchdogCycles) @(posedge CLK);
		$display("Timeout: the tests did not finish within %0d cycles", watchdogCycles);
		$display("Test failed");
		$finish;
	end

	task automatic compareValue(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		checkCount++;
		if (got !== expected)
		begin
			errorCount++;
			$display("FAIL %0t %s got %0h expected %0h", $time, name, got, expected);
		end
	endtask

	////////////////////////////////////////
	// Pixel model
	function automatic logic [6:0] digitSegments(input logic [3:0] d);  // {a,b,c,d,e,f,g}
		case (d)
			4'd0: return 7'b1111110;
			4'd1: return 7'b0110000;
			4'd2: return 7'b1101101;
			4'd3: return 7'b1111001;
			4'd4: return 7'b0110011;
			4'd5: return 7'b1011011;
			4'd6: return 7'b1011111;
			4'd7: return 7'b1110000;
			4'd8: return 7'b1111111;
			4'd9: return 7'b1111011;
			default: return 7'b0000000;
		endcase
	endfunction

	function automatic logic insideBox(input int h, input int v, input int xl, input int xh,
		input int yl, input int yh);
		return h >= xl && h <= xh && v >= yl && v <= yh;
	endfunction

	function automatic int pointedField(input logic [7:0] code);  // Field plus one or 0 for none
		case (code)
			8'h26: return 1;
			8'h25: return 2;
			8'h24: return 3;
			8'h23: return 4;
			8'h22: return 5;
			8'h21: return 6;
			8'h43: return 7;
			8'h42: return 8;
			8'h41: return 9;
			default: return 0;
		endcase
	endfunction

	function automatic logic [11:0] pixelModel(input int h, input int v);
		int k;
		int off;
		int row;
		int col;
		int sel;
		logic [6:0] seg;
		logic lit;
		logic [11:0] base;
		lit = 1'b0;
		sel = 0;
		if (h >= 640 || v >= 480)
			return 12'h000;                             // Blanking
		if (v >= 200 && v <= 223 && h >= 64 && h < 64 + 9 * 40)
		begin
			k = (h - 64) / 40;
			off = (h - 64) % 40;
			sel = k + 1;
			row = v - 200;
			col = off % 16;
			seg = digitSegments(off < 16 ? fieldModel[k][7:4] : fieldModel[k][3:0]);
			if (off < 32)
			begin
				if (col >= 3 && col <= 12)
					lit = (seg[6] && row <= 2) || (seg[0] && row >= 11 && row <= 13)
						|| (seg[3] && row >= 21);       // a g d
				else if (col <= 2)
					lit = (seg[1] && row >= 2 && row <= 11) || (seg[2] && row >= 13 && row <= 22);
				else
					lit = (seg[5] && row >= 2 && row <= 11) || (seg[4] && row >= 13 && row <= 22);
			end
		end
		lit = lit || insideBox(h, v, 490, 521, 67, 92) || insideBox(h, v, 490, 521, 95, 115)
			|| insideBox(h, v, 522, 550, 95, 115) || insideBox(h, v, 465, 487, 95, 115)
			|| (alarm && insideBox(h, v, 440, 455, 200, 223));
		base = lit ? 12'hFFF : 12'h000;
		if (keyPrevious != 8'hF0 && base == 12'hFFF
			&& ((keyCode == 8'h75 && insideBox(h, v, 490, 521, 67, 92))
			|| (keyCode == 8'h72 && insideBox(h, v, 490, 521, 95, 115))
			|| (keyCode == 8'h74 && insideBox(h, v, 522, 550, 95, 115))
			|| (keyCode == 8'h6B && insideBox(h, v, 465, 487, 95, 115))))
			return 12'hF00;                             // Held arrow
		if (sel != 0 && sel == pointedField(pointerModel) && base != 12'h000)
			return 12'hF00;
		return base;
	endfunction

	function automatic logic [7:0] remainingBcd(input logic [7:0] limit, input logic [7:0] value);
		int diff;
		diff = (limit[7:4] * 10 + limit[3:0] - value[7:4] * 10 - value[3:0] + 100) % 100;
		return {4'(diff / 10), 4'(diff % 10)};
	endfunction

	////////////////////////////////////////
	// Bus and sampling helpers
	task automatic writePort(input logic [7:0] addr, input logic [7:0] data);
		@(posedge CLK);
		writeStrobe <= 1'b1;
		portId <= addr;
		outPort <= data;
		@(posedge CLK);
		writeStrobe <= 1'b0;
		case (addr)
			8'h05: fieldModel[0] = data;
			8'h04: fieldModel[3] = data;
			8'h0A: fieldModel[6] = remainingBcd(8'h23, data);
			8'h09: fieldModel[7] = remainingBcd(8'h59, data);
			8'h08: fieldModel[8] = remainingBcd(8'h59, data);
			8'h0E: pointerModel = data;
			default: ;
		endcase
	endtask

	// Cycle n shows pixel n-2
	task automatic checkPixel(input int h, input int v, input logic [11:0] expected);
		longint target;
		@(posedge CLK);
		#1;
		target = cycleCount - (cycleCount % frameCycles) + longint'(v * 800 + h + 2);
		if (target <= cycleCount)
			target += frameCycles;
		while (cycleCount < target)
		begin
			@(posedge CLK);
			#1;
		end
		compareValue($sformatf("rgb(%0d,%0d)", h, v), 32'(rgb), 32'(expected));
	endtask

	task automatic checkFields(input int first, input int last);  // Raster order within one frame
		int rows [5] = '{201, 205, 212, 218, 222};
		int cols [3] = '{1, 7, 14};
		for (int r = 0; r < 5; r++)
			for (int k = first; k <= last; k++)
				for (int d = 0; d < 2; d++)
					for (int c = 0; c < 3; c++)
						checkPixel(64 + 40 * k + 16 * d + cols[c], rows[r],
							pixelModel(64 + 40 * k + 16 * d + cols[c], rows[r]));
	endtask

	task automatic waitSync(input logic useV, input logic level, output longint at);
		do
		begin
			@(posedge CLK);
			#1;
		end
		while ((useV ? vs : hs) !== level);
		at = cycleCount;
	endtask

	////////////////////////////////////////
	// Directed tests
	task automatic testSyncTiming();
		longint a;
		longint b;
		longint c;
		compareValue("hs", 32'(hs), 32'd1);
		compareValue("vs", 32'(vs), 32'd1);
		compareValue("rgb", 32'(rgb), 32'h000);
		waitSync(1'b0, 1'b0, a);
		waitSync(1'b0, 1'b1, b);
		waitSync(1'b0, 1'b0, c);
		compareValue("hs low width", 32'(b - a), 32'd96);
		compareValue("hs period", 32'(c - a), 32'd800);
		waitSync(1'b1, 1'b0, a);
		waitSync(1'b1, 1'b1, b);
		waitSync(1'b1, 1'b0, c);
		compareValue("vs low width", 32'(b - a), 32'd1600);
		compareValue("vs period", 32'(c - a), 32'd420000);
	endtask

	task automatic testResetDigits();
		checkFields(0, 8);
	endtask

	task automatic testDirectWrites();
		writePort(8'h04, 8'h17);
		writePort(8'h05, 8'h28);
		checkFields(0, 5);
	endtask

	task automatic testTimer();
		writePort(8'h08, 8'h15);
		writePort(8'h0A, 8'h07);
		checkFields(6, 8);
	endtask

	task automatic testPointer();
		writePort(8'h0E, 8'h22);                        // Minute under edit
		checkFields(3, 5);
		writePort(8'h0E, 8'h00);
		checkFields(3, 5);
	endtask

	task automatic testKeysAndAlarm();
		@(posedge CLK);
		keyCode <= 8'h75;
		keyPrevious <= 8'h00;
		checkPixel(500, 80, 12'hF00);                   // Up box held
		checkPixel(500, 100, 12'hFFF);
		@(posedge CLK);
		keyPrevious <= 8'hF0;                           // Released
		checkPixel(500, 80, 12'hFFF);
		@(posedge CLK);
		alarm <= 1'b1;
		checkPixel(447, 210, 12'hFFF);
		@(posedge CLK);
		alarm <= 1'b0;
		checkPixel(447, 210, 12'h000);
	endtask

	initial
	begin
		reset = 1'b1;
		keyCode = 8'h00;
		keyPrevious = 8'h00;
		alarm = 1'b0;
		writeStrobe = 1'b0;
		portId = 8'h00;
		outPort = 8'h00;
		fieldModel = '{8'h30, 8'h20, 8'h10, 8'h40, 8'h50, 8'h60, 8'h70, 8'h80, 8'h90};
		pointerModel = 8'h00;
		repeat (4) @(posedge CLK);
		reset <= 1'b0;
		testSyncTiming();
		testResetDigits();
		testDirectWrites();
		testTimer();
		testPointer();
		testKeysAndAlarm();
		$display("Checks: %0d, errors: %0d", checkCount, errorCount);
		if (errorCount == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

// ==== clockDisplay.f ====
common/clockDisplayPkg.sv
common/clockFieldsIf.sv
common/rasterIf.sv
logic/bcdSubtract.sv
logic/portRegisterBank.sv
vga/vgaTiming.sv
vga/fieldRenderer.sv
vga/highlightOverlay.sv
logic/clockDisplayTop.sv
testbench/clockDisplayTb.sv

// ==== Makefile ====
TOP = clockDisplayTb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -j 0 --top-module $(TOP) -f clockDisplay.f -o $(TOP)

run: build
	@out="$$(./obj_dir/$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "Test passed"

lint:
	verilator --lint-only --timing --top-module $(TOP) -f clockDisplay.f

clean:
	rm -rf obj_dir
